// File: fpu_config.svh
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// ========================================
// Floating-point slot build parameters
// ========================================

// Width of an operand or result word
`define FPU_WID 32

// Width of the function field of the instruction word
`define FPU_FUNC_WID 5

// Register stages between an operand change and a valid convert result
`define FPU_CVT_LAT 2

// Latency counter width, wide enough to hold FPU_CVT_LAT without wrapping
`define FPU_CNT_WID 4

`endif

// File: fpu_pkg.sv
`include "fpu_config.svh"

package fpu_pkg;

	// ========================================
	// Word types
	// ========================================

	// Single-precision float or two's complement integer
	typedef logic [`FPU_WID-1:0] fp_word_t;

	// Function code and major opcode fields of the instruction word
	typedef logic [`FPU_FUNC_WID-1:0] fpu_func_t;
	typedef logic [6:0] fpu_opcode_t;

	// Rounding mode, 0 is nearest-even and 1 is toward zero
	typedef logic [2:0] rnd_mode_t;

	// Opcode sits in the upper bits, function code in the lower bits
	typedef struct packed {
		fpu_opcode_t opcode;
		fpu_func_t   func;
	} fpu_instr_t;

	// ========================================
	// Opcode and function codes
	// ========================================

	parameter fpu_opcode_t OP_FLT = 7'h4c;

	// Sign manipulation
	parameter fpu_func_t FN_FABS   = 5'h00;
	parameter fpu_func_t FN_FNEG   = 5'h01;
	parameter fpu_func_t FN_SGNJ   = 5'h02;
	parameter fpu_func_t FN_SGNJN  = 5'h03;
	parameter fpu_func_t FN_SGNJX  = 5'h04;
	// Classification
	parameter fpu_func_t FN_ISNAN  = 5'h05;
	parameter fpu_func_t FN_FINITE = 5'h06;
	parameter fpu_func_t FN_FSIGN  = 5'h07;
	// Comparison
	parameter fpu_func_t FN_FSEQ   = 5'h08;
	parameter fpu_func_t FN_FSNE   = 5'h09;
	parameter fpu_func_t FN_FSLT   = 5'h0a;
	parameter fpu_func_t FN_FSLE   = 5'h0b;
	parameter fpu_func_t FN_FCMP   = 5'h0c;
	// Pipelined conversions
	parameter fpu_func_t FN_FTOI   = 5'h10;
	parameter fpu_func_t FN_ITOF   = 5'h11;
	parameter fpu_func_t FN_FTRUNC = 5'h12;

	// Sub-operation codes of the convert unit
	parameter logic [1:0] CVT_FTOI   = 2'd0;
	parameter logic [1:0] CVT_ITOF   = 2'd1;
	parameter logic [1:0] CVT_FTRUNC = 2'd2;

	// Decoded control shared by the execute units and the result stage
	typedef struct packed {
		logic       valid;
		logic       cvt_sel;
		logic [1:0] cvt_op;
		fpu_func_t  func;
	} fpu_ctrl_t;

endpackage

// File: fpu_decode.sv
module fpu_decode (
	input  fpu_pkg::fpu_instr_t instr,
	output fpu_pkg::fpu_ctrl_t  ctrl
);

	// Only the scalar float major opcode is handled by this slot
	logic op_hit;

	assign op_hit = (instr.opcode == fpu_pkg::OP_FLT);

	// ========================================
	// Function lookup
	// ========================================

	always_comb begin
		ctrl.valid   = 1'b0;
		ctrl.cvt_sel = 1'b0;
		ctrl.cvt_op  = fpu_pkg::CVT_FTOI;
		// The function code goes through untouched so the compare unit
		// can pick its result without looking at the instruction again
		ctrl.func    = instr.func;
		if (op_hit) begin
			case (instr.func)
				// Single-cycle operations handled by the compare/sign unit
				fpu_pkg::FN_FABS,
				fpu_pkg::FN_FNEG,
				fpu_pkg::FN_SGNJ,
				fpu_pkg::FN_SGNJN,
				fpu_pkg::FN_SGNJX,
				fpu_pkg::FN_ISNAN,
				fpu_pkg::FN_FINITE,
				fpu_pkg::FN_FSIGN,
				fpu_pkg::FN_FSEQ,
				fpu_pkg::FN_FSNE,
				fpu_pkg::FN_FSLT,
				fpu_pkg::FN_FSLE,
				fpu_pkg::FN_FCMP: begin
					ctrl.valid = 1'b1;
				end
				// Conversions run through the two-stage pipeline
				fpu_pkg::FN_FTOI: begin
					ctrl.valid   = 1'b1;
					ctrl.cvt_sel = 1'b1;
					ctrl.cvt_op  = fpu_pkg::CVT_FTOI;
				end
				fpu_pkg::FN_ITOF: begin
					ctrl.valid   = 1'b1;
					ctrl.cvt_sel = 1'b1;
					ctrl.cvt_op  = fpu_pkg::CVT_ITOF;
				end
				fpu_pkg::FN_FTRUNC: begin
					ctrl.valid   = 1'b1;
					ctrl.cvt_sel = 1'b1;
					ctrl.cvt_op  = fpu_pkg::CVT_FTRUNC;
				end
				// Unlisted codes stay invalid and read back as zero
				default: begin
					ctrl.valid = 1'b0;
				end
			endcase
		end
	end

endmodule

// File: fpu_cmp_sign.sv
module fpu_cmp_sign (
	input  fpu_pkg::fpu_ctrl_t ctrl,
	input  fpu_pkg::fp_word_t  a,
	input  fpu_pkg::fp_word_t  b,
	output fpu_pkg::fp_word_t  cs_res
);

	logic              a_nan;
	logic              b_nan;
	logic              any_nan;
	logic              both_zero;
	logic              eq;
	logic              lt;
	logic              le;
	fpu_pkg::fp_word_t cmp_word;
	fpu_pkg::fp_word_t sign_word;

	// ========================================
	// Compare word
	// ========================================

	// NaN has an all-ones exponent and a nonzero fraction
	assign a_nan   = (&a[30:23]) && (|a[22:0]);
	assign b_nan   = (&b[30:23]) && (|b[22:0]);
	assign any_nan = a_nan | b_nan;

	// Plus and minus zero compare equal, so ignore the sign here
	assign both_zero = ~|a[30:0] && ~|b[30:0];

	assign eq = !any_nan && ((a == b) || both_zero);

	always_comb begin
		lt = 1'b0;
		if (!any_nan && !both_zero) begin
			case ({a[31], b[31]})
				2'b10:   lt = 1'b1;
				2'b01:   lt = 1'b0;
				// Same sign; for negatives the larger magnitude is smaller
				2'b00:   lt = (a[30:0] < b[30:0]);
				default: lt = (a[30:0] > b[30:0]);
			endcase
		end
	end

	assign le       = eq | lt;
	assign cmp_word = {29'd0, le, lt, eq};

	// Sign of a as +1.0, -1.0 or zero, a NaN passes through unchanged
	always_comb begin
		if (a_nan)
			sign_word = a;
		else if (~|a[30:0])
			sign_word = 32'h0000_0000;
		else
			sign_word = a[31] ? 32'hbf80_0000 : 32'h3f80_0000;
	end

	// ========================================
	// Result select
	// ========================================

	always_comb begin
		cs_res = '0;
		if (ctrl.valid) begin
			case (ctrl.func)
				fpu_pkg::FN_FABS:   cs_res = {1'b0, a[30:0]};
				fpu_pkg::FN_FNEG:   cs_res = {~a[31], a[30:0]};
				fpu_pkg::FN_SGNJ:   cs_res = {a[31], b[30:0]};
				fpu_pkg::FN_SGNJN:  cs_res = {~a[31], b[30:0]};
				fpu_pkg::FN_SGNJX:  cs_res = {a[31] ^ b[31], b[30:0]};
				fpu_pkg::FN_ISNAN:  cs_res = {31'd0, a_nan};
				fpu_pkg::FN_FINITE: cs_res = {31'd0, ~&a[30:23]};
				fpu_pkg::FN_FSIGN:  cs_res = sign_word;
				fpu_pkg::FN_FSEQ:   cs_res = {31'd0, cmp_word[0]};
				fpu_pkg::FN_FSNE:   cs_res = {31'd0, ~cmp_word[0]};
				fpu_pkg::FN_FSLT:   cs_res = {31'd0, cmp_word[1]};
				fpu_pkg::FN_FSLE:   cs_res = {31'd0, cmp_word[2]};
				fpu_pkg::FN_FCMP:   cs_res = cmp_word;
				// Conversion codes are answered by the convert unit
				default:            cs_res = '0;
			endcase
		end
	end

endmodule

// File: fpu_convert.sv
module fpu_convert (
	input  logic               clk,
	input  logic               rst,
	input  logic [1:0]         cvt_op,
	input  fpu_pkg::rnd_mode_t rm,
	input  fpu_pkg::fp_word_t  a,
	output fpu_pkg::fp_word_t  cvt_res
);

	// Unpacked operand held between the two register stages
	typedef struct packed {
		logic [1:0]         op;
		fpu_pkg::rnd_mode_t rm;
		logic               sign;
		logic [7:0]         exp;
		logic [23:0]        man;
		logic [31:0]        mag;
		logic [4:0]         msb;
	} cvt_stage_t;

	cvt_stage_t        s1_d;
	cvt_stage_t        s1_q;
	logic [31:0]       in_mag;
	logic [4:0]        in_msb;
	logic [7:0]        k;
	logic [31:0]       ftoi_mag;
	fpu_pkg::fp_word_t ftoi_res;
	logic [22:0]       frac_mask;
	fpu_pkg::fp_word_t trunc_res;
	logic [31:0]       norm;
	logic              rnd_up;
	logic [23:0]       man_rnd;
	fpu_pkg::fp_word_t itof_res;

	// ========================================
	// Stage 1: unpack
	// ========================================

	// Integer magnitude for itof; the most negative value stays 2^31
	assign in_mag = a[31] ? (~a + 32'd1) : a;

	// Leading-one position, the highest set bit wins
	always_comb begin
		in_msb = 5'd0;
		for (int i = 0; i < 32; i++) begin
			if (in_mag[i])
				in_msb = 5'(i);
		end
	end

	always_comb begin
		s1_d.op   = cvt_op;
		s1_d.rm   = rm;
		s1_d.sign = a[31];
		s1_d.exp  = a[30:23];
		// Hidden bit is set for every nonzero exponent
		s1_d.man  = {|a[30:23], a[22:0]};
		s1_d.mag  = in_mag;
		s1_d.msb  = in_msb;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			s1_q <= '0;
		else
			s1_q <= s1_d;
	end

	// ========================================
	// Stage 2: shift, round and pack
	// ========================================

	// Unbiased exponent, only meaningful when exp is at least the bias
	assign k = s1_q.exp - 8'd127;

	// Float to integer, truncating toward zero with saturation
	always_comb begin
		ftoi_mag = '0;
		if (k >= 8'd23)
			ftoi_mag = {8'd0, s1_q.man} << (k - 8'd23);
		else
			ftoi_mag = {8'd0, s1_q.man} >> (8'd23 - k);
		if ((&s1_q.exp) && (|s1_q.man[22:0]))
			ftoi_res = 32'h7fff_ffff;
		else if (s1_q.exp >= 8'd158)
			ftoi_res = s1_q.sign ? 32'h8000_0000 : 32'h7fff_ffff;
		else if (s1_q.exp < 8'd127)
			ftoi_res = 32'h0000_0000;
		else
			ftoi_res = s1_q.sign ? (~ftoi_mag + 32'd1) : ftoi_mag;
	end

	// Clear the fraction bits below the binary point
	always_comb begin
		frac_mask = 23'h7f_ffff;
		if (k < 8'd23)
			frac_mask = 23'h7f_ffff << (8'd23 - k);
		if (s1_q.exp >= 8'd150)
			trunc_res = {s1_q.sign, s1_q.exp, s1_q.man[22:0]};
		else if (s1_q.exp < 8'd127)
			trunc_res = {s1_q.sign, 31'd0};
		else
			trunc_res = {s1_q.sign, s1_q.exp, s1_q.man[22:0] & frac_mask};
	end

	// Integer to float; bit 31 of norm is the leading one
	assign norm = s1_q.mag << (5'd31 - s1_q.msb);

	// Nearest-even rounds up past half or on a tie with an odd lsb
	assign rnd_up  = (s1_q.rm != 3'd1) && norm[7] && ((|norm[6:0]) || norm[8]);
	assign man_rnd = {1'b0, norm[30:8]} + {23'd0, rnd_up};

	always_comb begin
		if (~|s1_q.mag)
			itof_res = 32'h0000_0000;
		else
			// A carry out of the mantissa bumps the exponent by one
			itof_res = {s1_q.sign, 8'd127 + {3'd0, s1_q.msb} + {7'd0, man_rnd[23]},
				man_rnd[22:0]};
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cvt_res <= '0;
		end else begin
			case (s1_q.op)
				fpu_pkg::CVT_FTOI:   cvt_res <= ftoi_res;
				fpu_pkg::CVT_ITOF:   cvt_res <= itof_res;
				fpu_pkg::CVT_FTRUNC: cvt_res <= trunc_res;
				default:             cvt_res <= '0;
			endcase
		end
	end

endmodule

// File: fpu_result.sv
`include "fpu_config.svh"

module fpu_result (
	input  logic                clk,
	input  logic                rst,
	input  logic                idle,
	input  fpu_pkg::fpu_instr_t instr,
	input  fpu_pkg::fpu_ctrl_t  ctrl,
	input  fpu_pkg::fp_word_t   a,
	input  fpu_pkg::fp_word_t   b,
	input  fpu_pkg::fp_word_t   cvt_res,
	input  fpu_pkg::fp_word_t   cs_res,
	output fpu_pkg::fp_word_t   res,
	output logic                done
);

	// Everything whose change restarts the latency count
	typedef struct packed {
		fpu_pkg::fpu_instr_t instr;
		fpu_pkg::fp_word_t   a;
		fpu_pkg::fp_word_t   b;
	} fpu_args_t;

	// Convert latency at the counter width
	localparam logic [`FPU_CNT_WID-1:0] CVT_LAT = `FPU_CVT_LAT;

	fpu_args_t              args_cur;
	fpu_args_t              args_q;
	logic                   arg_chg;
	logic [`FPU_CNT_WID-1:0] cnt;

	// ========================================
	// Argument change detector
	// ========================================

	assign args_cur = '{instr: instr, a: a, b: b};

	// A mismatch against last cycle's copy marks a new operation
	assign arg_chg = (args_cur != args_q);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			args_q <= '0;
		else
			args_q <= args_cur;
	end

	// Cleared by a change, then counts up and holds at all ones
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			cnt <= '0;
		else if (arg_chg)
			cnt <= '0;
		else if (cnt != '1)
			cnt <= cnt + 1'b1;
	end

	// ========================================
	// Done and result select
	// ========================================

	// A conversion waits for the pipeline, everything else is immediate
	always_comb begin
		if (idle)
			done = 1'b0;
		else if (ctrl.cvt_sel)
			done = !arg_chg && (cnt >= CVT_LAT);
		else
			done = 1'b1;
	end

	// Invalid codes come back as zero from the compare/sign unit
	assign res = ctrl.cvt_sel ? cvt_res : cs_res;

endmodule

// File: fpu_top.sv
module fpu_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                idle,
	input  fpu_pkg::fpu_instr_t instr,
	input  fpu_pkg::rnd_mode_t  rm,
	input  fpu_pkg::fp_word_t   a,
	input  fpu_pkg::fp_word_t   b,
	output fpu_pkg::fp_word_t   res,
	output logic                done
);

	fpu_pkg::fpu_ctrl_t ctrl;
	fpu_pkg::fp_word_t  cvt_res;
	fpu_pkg::fp_word_t  cs_res;

	// Instruction decode, shared by both execute units
	fpu_decode u_decode (
		.instr (instr),
		.ctrl  (ctrl)
	);

	// Single-cycle compare, sign and class operations
	fpu_cmp_sign u_cmp_sign (
		.ctrl   (ctrl),
		.a      (a),
		.b      (b),
		.cs_res (cs_res)
	);

	// Free-running two-stage conversion pipeline
	fpu_convert u_convert (
		.clk     (clk),
		.rst     (rst),
		.cvt_op  (ctrl.cvt_op),
		.rm      (rm),
		.a       (a),
		.cvt_res (cvt_res)
	);

	// Latency tracking and output mux
	fpu_result u_result (
		.clk     (clk),
		.rst     (rst),
		.idle    (idle),
		.instr   (instr),
		.ctrl    (ctrl),
		.a       (a),
		.b       (b),
		.cvt_res (cvt_res),
		.cs_res  (cs_res),
		.res     (res),
		.done    (done)
	);

endmodule

// File: fpu_assertions.sv
`include "fpu_config.svh"

module fpu_assertions (
	input logic                    clk,
	input logic                    rst,
	input logic                    idle,
	input logic                    done,
	input logic                    arg_chg,
	input logic [`FPU_CNT_WID-1:0] cnt,
	input fpu_pkg::fpu_ctrl_t      ctrl,
	input fpu_pkg::fp_word_t       res
);

	timeunit 1ns;
	timeprecision 1ps;

	// Number of failed assertions, read by the testbench
	int fail_cnt = 0;

	// ========================================
	// Done and result properties
	// ========================================

	// Idle masks done for every instruction
	idle_masks_done: assert property (@(posedge clk) disable iff (rst) idle |-> !done)
	else begin
		$error("done is high while idle is high");
		fail_cnt++;
	end

	// The pipeline has not caught up one cycle after new arguments
	cvt_not_early: assert property (@(posedge clk) disable iff (rst)
		(ctrl.cvt_sel && $past(arg_chg)) |-> !done)
	else begin
		$error("conversion done one cycle after an argument change");
		fail_cnt++;
	end

	// Once the latency has run out the output holds until the arguments move
	res_holds: assert property (@(posedge clk) disable iff (rst)
		(!arg_chg && $past(!arg_chg && (cnt >= `FPU_CVT_LAT))) |-> $stable(res))
	else begin
		$error("result changed while the arguments were unchanged");
		fail_cnt++;
	end

endmodule

// File: tb_fpu.sv
module tb_fpu;

	timeunit 1ns;
	timeprecision 1ps;

	// ========================================
	// Run length and stimulus tables
	// ========================================

	localparam int N_DIRECTED = 11;
	localparam int N_RANDOM   = 400;
	// A conversion needs about six cycles with its hold and idle cycles, eight leaves margin
	localparam int CYCLE_LIMIT = (N_DIRECTED + N_RANDOM) * 8 + 50;

	localparam fpu_pkg::fpu_func_t VALID_CODES [16] = '{
		fpu_pkg::FN_FABS, fpu_pkg::FN_FNEG, fpu_pkg::FN_SGNJ, fpu_pkg::FN_SGNJN,
		fpu_pkg::FN_SGNJX, fpu_pkg::FN_ISNAN, fpu_pkg::FN_FINITE, fpu_pkg::FN_FSIGN,
		fpu_pkg::FN_FSEQ, fpu_pkg::FN_FSNE, fpu_pkg::FN_FSLT, fpu_pkg::FN_FSLE,
		fpu_pkg::FN_FCMP, fpu_pkg::FN_FTOI, fpu_pkg::FN_ITOF, fpu_pkg::FN_FTRUNC
	};

	logic                clk = 1'b0;
	logic                rst;
	logic                idle;
	fpu_pkg::fpu_instr_t instr;
	fpu_pkg::rnd_mode_t  rm;
	fpu_pkg::fp_word_t   a;
	fpu_pkg::fp_word_t   b;
	fpu_pkg::fp_word_t   res;
	logic                done;
	integer              seed;
	int                  cycles = 0;

	fpu_top UUT (
		.clk   (clk),
		.rst   (rst),
		.idle  (idle),
		.instr (instr),
		.rm    (rm),
		.a     (a),
		.b     (b),
		.res   (res),
		.done  (done)
	);

	// Checker sits on the result stage where the counter and change flag live
	bind fpu_result fpu_assertions u_assert (
		.clk     (clk),
		.rst     (rst),
		.idle    (idle),
		.done    (done),
		.arg_chg (arg_chg),
		.cnt     (cnt),
		.ctrl    (ctrl),
		.res     (res)
	);

	always #5 clk = ~clk;

	// Watchdog over the whole run, also picks up a failed bound assertion
	always @(negedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end else if (UUT.u_result.u_assert.fail_cnt != 0) begin
			$display("A bound assertion on the result stage failed");
			$display("STATUS: FAIL");
			$fatal(1, "assertion failure");
		end
	end

	// ========================================
	// Reference model
	// ========================================

	function automatic logic nan_of(fpu_pkg::fp_word_t x);
		return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
	endfunction

	// Ordering key turns float order into unsigned order, zeros handled apart
	function automatic fpu_pkg::fp_word_t cmp_of(fpu_pkg::fp_word_t x, fpu_pkg::fp_word_t y);
		logic [31:0] kx;
		logic [31:0] ky;
		logic        eq;
		logic        lt;
		kx = x[31] ? ~x : (x | 32'h8000_0000);
		ky = y[31] ? ~y : (y | 32'h8000_0000);
		if (nan_of(x) || nan_of(y))
			return '0;
		eq = (x == y) || ((x[30:0] == 31'd0) && (y[30:0] == 31'd0));
		lt = !eq && (kx < ky);
		return {29'd0, eq | lt, lt, eq};
	endfunction

	function automatic fpu_pkg::fp_word_t ftoi_of(fpu_pkg::fp_word_t x);
		int          e;
		logic [63:0] m;
		e = int'(x[30:23]);
		m = {40'd0, 1'b1, x[22:0]};
		if (nan_of(x))
			return 32'h7fff_ffff;
		if (e < 127)
			return '0;
		if (e >= 158)
			return x[31] ? 32'h8000_0000 : 32'h7fff_ffff;
		m = (e >= 150) ? (m << (e - 150)) : (m >> (150 - e));
		return x[31] ? (~m[31:0] + 32'd1) : m[31:0];
	endfunction

	// Keep 24 bits below the leading one, then round on the dropped tail
	function automatic fpu_pkg::fp_word_t itof_of(fpu_pkg::fp_word_t x, fpu_pkg::rnd_mode_t r);
		logic [63:0] mag;
		logic [63:0] kept;
		logic [63:0] rem;
		logic [63:0] half;
		int          p;
		int          drop;
		if (x == '0)
			return '0;
		mag = x[31] ? {32'd0, ~x + 32'd1} : {32'd0, x};
		p = 0;
		for (int i = 0; i < 32; i++)
			if (mag[i])
				p = i;
		if (p <= 23) begin
			kept = mag << (23 - p);
		end else begin
			drop = p - 23;
			kept = mag >> drop;
			rem  = mag & ((64'd1 << drop) - 64'd1);
			half = 64'd1 << (drop - 1);
			if ((r != 3'd1) && ((rem > half) || ((rem == half) && kept[0])))
				kept = kept + 64'd1;
			if (kept[24]) begin
				kept = kept >> 1;
				p    = p + 1;
			end
		end
		return {x[31], 8'(p + 127), kept[22:0]};
	endfunction

	function automatic fpu_pkg::fp_word_t ftrunc_of(fpu_pkg::fp_word_t x);
		int e;
		e = int'(x[30:23]);
		if (e >= 150)
			return x;
		if (e < 127)
			return {x[31], 31'd0};
		return {x[31:23], x[22:0] & ~((23'd1 << (150 - e)) - 23'd1)};
	endfunction

	function automatic fpu_pkg::fp_word_t expect_res(fpu_pkg::fpu_instr_t i,
		fpu_pkg::rnd_mode_t r, fpu_pkg::fp_word_t x, fpu_pkg::fp_word_t y);
		fpu_pkg::fp_word_t cw;
		cw = cmp_of(x, y);
		if (i.opcode != fpu_pkg::OP_FLT)
			return '0;
		case (i.func)
			fpu_pkg::FN_FABS:   return {1'b0, x[30:0]};
			fpu_pkg::FN_FNEG:   return {~x[31], x[30:0]};
			fpu_pkg::FN_SGNJ:   return {x[31], y[30:0]};
			fpu_pkg::FN_SGNJN:  return {~x[31], y[30:0]};
			fpu_pkg::FN_SGNJX:  return {x[31] ^ y[31], y[30:0]};
			fpu_pkg::FN_ISNAN:  return {31'd0, nan_of(x)};
			fpu_pkg::FN_FINITE: return {31'd0, x[30:23] != 8'hff};
			fpu_pkg::FN_FSIGN:
				if (nan_of(x))
					return x;
				else if (x[30:0] == 31'd0)
					return '0;
				else
					return {x[31], 8'd127, 23'd0};
			fpu_pkg::FN_FSEQ:   return {31'd0, cw[0]};
			fpu_pkg::FN_FSNE:   return {31'd0, ~cw[0]};
			fpu_pkg::FN_FSLT:   return {31'd0, cw[1]};
			fpu_pkg::FN_FSLE:   return {31'd0, cw[2]};
			fpu_pkg::FN_FCMP:   return cw;
			fpu_pkg::FN_FTOI:   return ftoi_of(x);
			fpu_pkg::FN_ITOF:   return itof_of(x, r);
			fpu_pkg::FN_FTRUNC: return ftrunc_of(x);
			default:            return '0;
		endcase
	endfunction

	function automatic logic is_cvt(fpu_pkg::fpu_instr_t i);
		return (i.opcode == fpu_pkg::OP_FLT) && ((i.func == fpu_pkg::FN_FTOI) ||
			(i.func == fpu_pkg::FN_ITOF) || (i.func == fpu_pkg::FN_FTRUNC));
	endfunction

	function automatic fpu_pkg::fpu_instr_t flt(fpu_pkg::fpu_func_t f);
		return {fpu_pkg::OP_FLT, f};
	endfunction

	// ========================================
	// Checks and stimulus
	// ========================================

	task automatic compare_word(string name, fpu_pkg::fp_word_t expected,
		fpu_pkg::fp_word_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "result mismatch");
		end
	endtask

	task automatic compare_done(string name, logic expected, logic actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected done %b, actual %b", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "done mismatch");
		end
	endtask

	// Mix of special classes and plain random words
	function automatic fpu_pkg::fp_word_t pick_operand();
		logic [31:0] r;
		logic [31:0] s;
		r = $random(seed);
		s = $random(seed);
		case (r[3:0])
			4'd0:    return {s[31], 31'd0};
			4'd1:    return {s[31], 8'hff, 23'd0};
			4'd2:    return {s[31], 8'hff, s[22:0] | 23'd1};
			4'd3:    return {s[31], 8'd150 + 8'(s[26:23]), s[22:0]};
			4'd4:    return {s[31], 8'd120 + 8'(s[27:23]), s[22:0]};
			4'd5:    return s[0] ? 32'h8000_0000 : 32'h7fff_ffff;
			default: return s;
		endcase
	endfunction

	// One transaction; the idle cycle parks instr at zero so the next one is a change
	task automatic run_op(string name, fpu_pkg::fpu_instr_t i, fpu_pkg::rnd_mode_t r,
		fpu_pkg::fp_word_t x, fpu_pkg::fp_word_t y);
		fpu_pkg::fp_word_t expected;
		logic              cvt;
		expected = expect_res(i, r, x, y);
		cvt      = is_cvt(i);
		@(posedge clk);
		idle  <= 1'b0;
		instr <= i;
		rm    <= r;
		a     <= x;
		b     <= y;
		@(negedge clk);
		compare_done({name, " first cycle"}, !cvt, done);
		while (!done)
			@(negedge clk);
		compare_word(name, expected, res);
		// The arguments stay one more cycle and the result has to hold still
		@(negedge clk);
		compare_word({name, " held"}, expected, res);
		compare_done({name, " held"}, 1'b1, done);
		@(posedge clk);
		idle  <= 1'b1;
		instr <= '0;
		@(negedge clk);
		compare_done({name, " idle"}, 1'b0, done);
	endtask

	task automatic run_directed();
		run_op("fseq zeros", flt(fpu_pkg::FN_FSEQ), 3'd0, 32'h0000_0000, 32'h8000_0000);
		run_op("fslt zeros", flt(fpu_pkg::FN_FSLT), 3'd0, 32'h8000_0000, 32'h0000_0000);
		run_op("fcmp nan", flt(fpu_pkg::FN_FCMP), 3'd0, 32'h7fc0_0000, 32'h3f80_0000);
		run_op("ftoi nan", flt(fpu_pkg::FN_FTOI), 3'd0, 32'hffc0_0001, 32'd0);
		run_op("ftoi sat", flt(fpu_pkg::FN_FTOI), 3'd0, 32'hd000_0000, 32'd0);
		run_op("itof min", flt(fpu_pkg::FN_ITOF), 3'd0, 32'h8000_0000, 32'd0);
		run_op("itof rne", flt(fpu_pkg::FN_ITOF), 3'd0, 32'h7fff_ffff, 32'd0);
		run_op("itof rtz", flt(fpu_pkg::FN_ITOF), 3'd1, 32'h7fff_ffff, 32'd0);
		run_op("ftrunc", flt(fpu_pkg::FN_FTRUNC), 3'd0, 32'hc020_0000, 32'd0);
		run_op("bad opcode", {~fpu_pkg::OP_FLT, fpu_pkg::FN_FABS}, 3'd0, 32'h1, 32'h2);
		run_op("bad func", {fpu_pkg::OP_FLT, 5'h1f}, 3'd0, 32'h3, 32'h4);
	endtask

	task automatic run_random();
		logic [31:0]         r;
		fpu_pkg::fpu_instr_t i;
		fpu_pkg::fp_word_t   x;
		fpu_pkg::fp_word_t   y;
		for (int n = 0; n < N_RANDOM; n++) begin
			r = $random(seed);
			x = pick_operand();
			y = pick_operand();
			// Equal and sign-flipped pairs exercise the compare edges
			if (r[5:4] == 2'd0)
				y = x;
			else if (r[5:4] == 2'd1)
				y = {~x[31], x[30:0]};
			i = flt(VALID_CODES[r[9:6]]);
			if (r[12:10] == 3'd0)
				i.opcode = ~fpu_pkg::OP_FLT;
			else if (r[12:10] == 3'd1)
				i.func = 5'h1f;
			run_op($sformatf("random %0d", n), i, r[13] ? 3'd1 : r[16:14], x, y);
		end
	endtask

	initial begin
		seed  = 32'hcf2b;
		rst   = 1'b1;
		idle  = 1'b1;
		instr = '0;
		rm    = '0;
		a     = '0;
		b     = '0;
		repeat (2) begin
			@(posedge clk);
			@(negedge clk);
			compare_done("reset", 1'b0, done);
		end
		@(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		compare_done("after reset", 1'b0, done);
		run_directed();
		run_random();
		if (UUT.u_result.u_assert.fail_cnt == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("STATUS: FAIL");
			$fatal(1, "assertion failure");
		end
	end

endmodule

// File: project.f
+incdir+.
fpu_pkg.sv
fpu_decode.sv
fpu_cmp_sign.sv
fpu_convert.sv
fpu_result.sv
fpu_top.sv
fpu_assertions.sv
tb_fpu.sv

// File: run.sh
#!/usr/bin/env bash
# Build the FPU testbench with Verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module tb_fpu -o sim_tb_fpu

# Raise the error limit so the testbench sees a failed assertion itself
status=0
./obj_dir/sim_tb_fpu +verilator+error+limit+100 2>&1 | tee "$LOG" || status=$?

if grep -q "STATUS: FAIL" "$LOG" || [ "$status" -ne 0 ]; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
